// ==== reflet_macros.svh ====
`ifndef REFLET_MACROS_SVH
`define REFLET_MACROS_SVH

// bus widths
`define REFLET_WORD_SIZE 16
`define REFLET_ADDR_SIZE 16

// first address of the register window
`define REFLET_BASE_ADDR 16'hFF00

// number of registers in each peripheral
`define REFLET_HWI_SIZE   4
`define REFLET_EXTI_SIZE  3
`define REFLET_GPIO_SIZE  4
`define REFLET_TIMER_SIZE 3
`define REFLET_PWM_SIZE   2

// register offsets inside the window
`define REFLET_HWI_OFF   0
`define REFLET_EXTI_OFF  (`REFLET_HWI_OFF + `REFLET_HWI_SIZE)
`define REFLET_GPIO_OFF  (`REFLET_EXTI_OFF + `REFLET_EXTI_SIZE)
`define REFLET_TIMER_OFF (`REFLET_GPIO_OFF + `REFLET_GPIO_SIZE)
`define REFLET_PWM_OFF   (`REFLET_TIMER_OFF + `REFLET_TIMER_SIZE)

// whole window
`define REFLET_TOTAL_SIZE  (`REFLET_PWM_OFF + `REFLET_PWM_SIZE)
`define REFLET_OFFSET_SIZE ($clog2(`REFLET_TOTAL_SIZE))

`endif

// ==== reflet_pkg.sv ====
`include "reflet_macros.svh"

package reflet_pkg;

    // one data word on the processor bus
    typedef logic [`REFLET_WORD_SIZE-1:0] word_t;

    // one processor bus address
    typedef logic [`REFLET_ADDR_SIZE-1:0] addr_t;

    // register index inside the peripheral window
    typedef logic [`REFLET_OFFSET_SIZE-1:0] offset_t;

    // interrupt lines
    // bit 0 gpio, bit 1 timer, bit 2 software trigger, bit 3 pwm
    typedef logic [3:0] irq_t;

    // local register bus, shared by every peripheral
    typedef struct packed {
        // access falls inside the window
        logic    sel;
        // register index relative to the base address
        offset_t offset;
        // write data
        word_t   wdata;
        // write strobe
        logic    we;
    } reg_bus_t;

endpackage

// ==== reflet_hardware_info.sv ====
`include "reflet_macros.svh"

module reflet_hardware_info #(
    parameter logic [31:0] clk_freq = 32'd1000000
) (
    input  reflet_pkg::reg_bus_t bus,
    output reflet_pkg::word_t    rdata
);
    import reflet_pkg::*;

    // exti, gpio, timer and pwm present
    localparam word_t PERIPH_MASK = 16'h000F;

    offset_t idx;
    logic    hit;

    assign hit = bus.sel && (bus.offset >= `REFLET_HWI_OFF)
              && (bus.offset < `REFLET_HWI_OFF + `REFLET_HWI_SIZE);
    assign idx = bus.offset - offset_t'(`REFLET_HWI_OFF);

    // read only, writes fall through
    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                0: rdata = word_t'(`REFLET_WORD_SIZE);
                1: rdata = clk_freq[15:0];
                2: rdata = clk_freq[31:16];
                3: rdata = PERIPH_MASK;
                default: rdata = '0;
            endcase
        end
    end

endmodule

// ==== reflet_exti.sv ====
`include "reflet_macros.svh"

module reflet_exti (
    input  logic                 clk,
    input  logic                 arst_n,
    input  reflet_pkg::reg_bus_t bus,
    output reflet_pkg::word_t    rdata,
    input  reflet_pkg::irq_t     src,
    output reflet_pkg::irq_t     ext_int
);
    import reflet_pkg::*;

    offset_t idx;
    logic    hit;
    logic    wr_mask;
    logic    wr_pend;
    logic    wr_trig;
    logic    sw_trig;
    irq_t    mask;
    irq_t    pending;
    irq_t    src_q;
    irq_t    src_all;
    irq_t    rise;
    irq_t    clr;

    assign hit = bus.sel && (bus.offset >= `REFLET_EXTI_OFF)
              && (bus.offset < `REFLET_EXTI_OFF + `REFLET_EXTI_SIZE);
    assign idx = bus.offset - offset_t'(`REFLET_EXTI_OFF);

    assign wr_mask = hit && bus.we && (idx == 0);
    assign wr_pend = hit && bus.we && (idx == 1);
    assign wr_trig = hit && bus.we && (idx == 2);

    // software trigger joins as source 2
    assign src_all = src | {1'b0, sw_trig, 2'b00};
    assign rise    = src_all & ~src_q;
    assign clr     = wr_pend ? bus.wdata[3:0] : '0;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mask    <= '0;
            pending <= '0;
            src_q   <= '0;
            sw_trig <= 1'b0;
        end
        else
        begin
            src_q   <= src_all;
            sw_trig <= wr_trig && bus.wdata[0];
            if (wr_mask)
                mask <= bus.wdata[3:0];
            // a new edge wins over a clear in the same cycle
            pending <= (pending & ~clr) | rise;
        end
    end

    assign ext_int = pending & mask;

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                0: rdata = word_t'(mask);
                1: rdata = word_t'(pending);
                default: rdata = '0;
            endcase
        end
    end

    // a mask written with a bit cleared keeps that line quiet
    assert property (@(posedge clk) disable iff (!arst_n)
        wr_mask |=> (ext_int & ~$past(bus.wdata[3:0])) == '0);

endmodule

// ==== reflet_gpio.sv ====
`include "reflet_macros.svh"

module reflet_gpio (
    input  logic                 clk,
    input  logic                 arst_n,
    input  reflet_pkg::reg_bus_t bus,
    output reflet_pkg::word_t    rdata,
    input  logic [15:0]          gpi,
    output logic [15:0]          gpo,
    output logic                 irq
);
    import reflet_pkg::*;

    offset_t     idx;
    logic        hit;
    logic        wr_gpo;
    logic        wr_mask;
    logic        wr_flag;
    logic [15:0] sync1;
    logic [15:0] sync2;
    logic [15:0] sync3;
    logic [15:0] mask;
    logic [15:0] flags;
    logic [15:0] rise;
    logic [15:0] clr;

    assign hit = bus.sel && (bus.offset >= `REFLET_GPIO_OFF)
              && (bus.offset < `REFLET_GPIO_OFF + `REFLET_GPIO_SIZE);
    assign idx = bus.offset - offset_t'(`REFLET_GPIO_OFF);

    assign wr_gpo  = hit && bus.we && (idx == 1);
    assign wr_mask = hit && bus.we && (idx == 2);
    assign wr_flag = hit && bus.we && (idx == 3);

    // sync3 only serves the edge detector
    assign rise = sync2 & ~sync3 & mask;
    assign clr  = wr_flag ? bus.wdata : '0;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync1 <= '0;
            sync2 <= '0;
            sync3 <= '0;
            gpo   <= '0;
            mask  <= '0;
            flags <= '0;
        end
        else
        begin
            sync1 <= gpi;
            sync2 <= sync1;
            sync3 <= sync2;
            if (wr_gpo)
                gpo <= bus.wdata;
            if (wr_mask)
                mask <= bus.wdata;
            flags <= (flags & ~clr) | rise;
        end
    end

    assign irq = |flags;

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                0: rdata = sync2;
                1: rdata = gpo;
                2: rdata = mask;
                3: rdata = flags;
                default: rdata = '0;
            endcase
        end
    end

endmodule

// ==== reflet_timer.sv ====
`include "reflet_macros.svh"

module reflet_timer (
    input  logic                 clk,
    input  logic                 arst_n,
    input  reflet_pkg::reg_bus_t bus,
    output reflet_pkg::word_t    rdata,
    output logic                 irq
);
    import reflet_pkg::*;

    offset_t idx;
    logic    hit;
    logic    wr_ctrl;
    logic    wr_period;
    logic    wr_count;
    logic    run;
    logic    ie;
    logic    flag;
    logic    wrap;
    word_t   period;
    word_t   count;

    assign hit = bus.sel && (bus.offset >= `REFLET_TIMER_OFF)
              && (bus.offset < `REFLET_TIMER_OFF + `REFLET_TIMER_SIZE);
    assign idx = bus.offset - offset_t'(`REFLET_TIMER_OFF);

    assign wr_ctrl   = hit && bus.we && (idx == 0);
    assign wr_period = hit && bus.we && (idx == 1);
    assign wr_count  = hit && bus.we && (idx == 2);

    // >= also recovers when the period is lowered under the count
    assign wrap = count >= period;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            run    <= 1'b0;
            ie     <= 1'b0;
            flag   <= 1'b0;
            period <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_ctrl)
            begin
                run <= bus.wdata[0];
                ie  <= bus.wdata[1];
            end
            if (wr_period)
                period <= bus.wdata;
            if (wr_count)
                count <= '0;
            else if (run)
                count <= wrap ? '0 : count + 1'b1;
            // writing 0 to bit 2 clears, overflow sets
            flag <= (flag && !(wr_ctrl && !bus.wdata[2])) || (run && wrap && !wr_count);
        end
    end

    assign irq = flag && ie;

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                0: rdata = {13'b0, flag, ie, run};
                1: rdata = period;
                2: rdata = count;
                default: rdata = '0;
            endcase
        end
    end

    // once the period has settled the count stays in range
    assert property (@(posedge clk) disable iff (!arst_n)
        (run && $past(run) && $stable(period) && period != '0) |-> count <= period);

endmodule

// ==== reflet_pwm.sv ====
`include "reflet_macros.svh"

module reflet_pwm (
    input  logic                 clk,
    input  logic                 arst_n,
    input  reflet_pkg::reg_bus_t bus,
    output reflet_pkg::word_t    rdata,
    output logic                 pwm,
    output logic                 irq
);
    import reflet_pkg::*;

    offset_t idx;
    logic    hit;
    logic    wrap;
    word_t   period;
    word_t   duty;
    word_t   cnt;

    assign hit = bus.sel && (bus.offset >= `REFLET_PWM_OFF)
              && (bus.offset < `REFLET_PWM_OFF + `REFLET_PWM_SIZE);
    assign idx = bus.offset - offset_t'(`REFLET_PWM_OFF);

    assign wrap = cnt >= period;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            period <= '0;
            duty   <= '0;
            cnt    <= '0;
            pwm    <= 1'b0;
            irq    <= 1'b0;
        end
        else
        begin
            if (hit && bus.we && idx == 0)
                period <= bus.wdata;
            if (hit && bus.we && idx == 1)
                duty <= bus.wdata;
            cnt <= wrap ? '0 : cnt + 1'b1;
            pwm <= cnt < duty;
            // period 0 means stopped, no wrap pulses
            irq <= wrap && (period != '0);
        end
    end

    always_comb
    begin
        rdata = '0;
        if (hit)
            rdata = (idx == 0) ? period : duty;
    end

endmodule

// ==== reflet_peripheral.sv ====
`include "reflet_macros.svh"

module reflet_peripheral #(
    parameter logic [31:0] clk_freq = 32'd1000000
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              enable,
    input  reflet_pkg::addr_t addr,
    input  reflet_pkg::word_t data_in,
    input  logic              write_en,
    output reflet_pkg::word_t data_out,
    input  logic [15:0]       gpi,
    output logic [15:0]       gpo,
    output logic              pwm,
    output reflet_pkg::irq_t  ext_int
);
    import reflet_pkg::*;

    reg_bus_t bus;
    logic     in_window;
    word_t    rdata_hwi;
    word_t    rdata_exti;
    word_t    rdata_gpio;
    word_t    rdata_timer;
    word_t    rdata_pwm;
    logic     irq_gpio;
    logic     irq_timer;
    logic     irq_pwm;
    irq_t     src;

    // window decode
    assign in_window = enable && (addr >= `REFLET_BASE_ADDR)
                    && (addr < `REFLET_BASE_ADDR + `REFLET_TOTAL_SIZE);

    assign bus.sel    = in_window;
    assign bus.offset = offset_t'(addr - addr_t'(`REFLET_BASE_ADDR));
    assign bus.wdata  = data_in;
    assign bus.we     = write_en;

    // peripherals not addressed return zero
    assign data_out = rdata_hwi | rdata_exti | rdata_gpio | rdata_timer | rdata_pwm;

    // bit 2 is filled in by the software trigger inside exti
    assign src = {irq_pwm, 1'b0, irq_timer, irq_gpio};

    reflet_hardware_info #(
        .clk_freq(clk_freq)
    ) hwi_i (
        .bus  (bus),
        .rdata(rdata_hwi)
    );

    reflet_exti exti_i (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (bus),
        .rdata  (rdata_exti),
        .src    (src),
        .ext_int(ext_int)
    );

    reflet_gpio gpio_i (
        .clk   (clk),
        .arst_n(arst_n),
        .bus   (bus),
        .rdata (rdata_gpio),
        .gpi   (gpi),
        .gpo   (gpo),
        .irq   (irq_gpio)
    );

    reflet_timer timer_i (
        .clk   (clk),
        .arst_n(arst_n),
        .bus   (bus),
        .rdata (rdata_timer),
        .irq   (irq_timer)
    );

    reflet_pwm pwm_i (
        .clk   (clk),
        .arst_n(arst_n),
        .bus   (bus),
        .rdata (rdata_pwm),
        .pwm   (pwm),
        .irq   (irq_pwm)
    );

    // register ranges of the peripherals never overlap
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({|rdata_hwi, |rdata_exti, |rdata_gpio, |rdata_timer, |rdata_pwm}));

endmodule

// ==== tb_reflet_peripheral.sv ====
module tb_reflet_peripheral;
    timeunit 1ns;
    timeprecision 100ps;
    import reflet_pkg::*;

    localparam addr_t HWI_BASE   = 16'hFF00;
    localparam addr_t EXTI_BASE  = 16'hFF04;
    localparam addr_t GPIO_BASE  = 16'hFF07;
    localparam addr_t TIMER_BASE = 16'hFF0B;
    localparam addr_t PWM_BASE   = 16'hFF0E;

    // cycle budget of each test
    localparam int RESET_CYC = 40;
    localparam int HWI_CYC   = 40;
    localparam int GPIO_CYC  = 60;
    localparam int TIMER_CYC = 200;
    localparam int PWM_CYC   = 200;
    localparam int EXTI_CYC  = 20;
    localparam int BUDGET_CYC = RESET_CYC + HWI_CYC + GPIO_CYC + TIMER_CYC + PWM_CYC + EXTI_CYC;
    localparam int WATCHDOG_NS = 20 * BUDGET_CYC * 8;

    logic        clk;
    logic        arst_n;
    logic        enable;
    addr_t       addr;
    word_t       data_in;
    logic        write_en;
    word_t       data_out;
    logic [15:0] gpi;
    logic [15:0] gpo;
    logic        pwm;
    irq_t        ext_int;
    integer      seed;
    int          errors;
    int          checks;

    reflet_peripheral #(
        .clk_freq(32'd1000000)
    ) dut_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .enable  (enable),
        .addr    (addr),
        .data_in (data_in),
        .write_en(write_en),
        .data_out(data_out),
        .gpi     (gpi),
        .gpo     (gpo),
        .pwm     (pwm),
        .ext_int (ext_int)
    );

    always #4 clk = ~clk;

    // every bus task starts and ends 1 ns after a rising edge
    task automatic bus_cycle(input logic en, input logic we, input addr_t a, input word_t d,
                             output word_t q);
        enable   = en;
        write_en = we;
        addr     = a;
        data_in  = d;
        #2;
        q = data_out;
        @(posedge clk);
        #1;
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic bus_write(input addr_t a, input word_t d);
        word_t q;
        bus_cycle(1'b1, 1'b1, a, d, q);
    endtask

    task automatic bus_read(input addr_t a, output word_t q);
        bus_cycle(1'b1, 1'b0, a, '0, q);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERROR %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_irq(input string name, input irq_t exp, input irq_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERROR %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic test_reset();
        word_t q;
        check_word("gpo", 16'h0000, gpo);
        check_word("pwm", 16'h0000, word_t'(pwm));
        check_irq("ext_int", 4'h0, ext_int);
        for (int i = 4; i < 16; i++)
        begin
            bus_read(HWI_BASE + addr_t'(i), q);
            check_word($sformatf("register %0d after reset", i), 16'h0000, q);
        end
    endtask

    task automatic test_hwi();
        word_t q;
        word_t exp [4] = '{16'd16, 16'h4240, 16'h000F, 16'h000F};
        for (int i = 0; i < 4; i++)
        begin
            bus_read(HWI_BASE + addr_t'(i), q);
            check_word($sformatf("hwi register %0d", i), exp[i], q);
        end
        bus_read(16'hFEFF, q);
        check_word("data_out below window", 16'h0000, q);
        bus_read(16'hFF10, q);
        check_word("data_out above window", 16'h0000, q);
        bus_cycle(1'b0, 1'b0, HWI_BASE, '0, q);
        check_word("data_out with enable low", 16'h0000, q);
        // these alias the gpo register in the low offset bits
        bus_write(16'hFEF8, 16'hA5A5);
        bus_write(16'hFF18, 16'hA5A5);
        bus_cycle(1'b0, 1'b1, GPIO_BASE + 1, 16'hA5A5, q);
        check_word("gpo after stray writes", 16'h0000, gpo);
        bus_read(GPIO_BASE + 1, q);
        check_word("gpo register after stray writes", 16'h0000, q);
    endtask

    task automatic test_gpio();
        word_t q;
        word_t v;
        for (int i = 0; i < 4; i++)
        begin
            v = word_t'($random(seed));
            bus_write(GPIO_BASE + 1, v);
            check_word("gpo", v, gpo);
            bus_read(GPIO_BASE + 1, q);
            check_word("gpo register", v, q);
        end
        for (int i = 0; i < 4; i++)
        begin
            v = word_t'($random(seed));
            gpi = v;
            wait_cycles(3);
            bus_read(GPIO_BASE, q);
            check_word("gpio input register", v, q);
        end
        gpi = 16'h0000;
        wait_cycles(3);
        bus_write(GPIO_BASE + 3, 16'hFFFF);
        bus_write(GPIO_BASE + 2, 16'h0001);
        // bit 0 masked, bit 1 not
        gpi = 16'h0003;
        wait_cycles(4);
        bus_read(GPIO_BASE + 3, q);
        check_word("gpio flags", 16'h0001, q);
        bus_write(GPIO_BASE + 3, 16'h0001);
        bus_read(GPIO_BASE + 3, q);
        check_word("gpio flags after clear", 16'h0000, q);
        bus_write(GPIO_BASE + 2, 16'h0000);
        bus_write(EXTI_BASE + 1, 16'h000F);
    endtask

    task automatic test_timer();
        word_t q;
        int    p;
        int    k;
        p = 3 + $unsigned($random(seed)) % 16;
        bus_write(TIMER_BASE + 1, word_t'(p));
        bus_write(TIMER_BASE, 16'h0003);
        for (int t = 0; t < 3; t++)
        begin
            k = 1 + $unsigned($random(seed)) % (2 * p);
            bus_write(TIMER_BASE + 2, 16'h0000);
            wait_cycles(k);
            bus_read(TIMER_BASE + 2, q);
            check_word("timer count", word_t'(k % (p + 1)), q);
        end
        // stop first, an overflow on that edge would set the flag again
        bus_write(TIMER_BASE, 16'h0002);
        bus_write(TIMER_BASE, 16'h0002);
        bus_write(TIMER_BASE + 2, 16'h0000);
        bus_write(EXTI_BASE + 1, 16'h000F);
        bus_read(TIMER_BASE, q);
        check_word("timer control stopped", 16'h0002, q);
        bus_write(TIMER_BASE, 16'h0003);
        wait_cycles(p + 1);
        bus_read(TIMER_BASE, q);
        check_word("timer control overflow", 16'h0007, q);
        check_irq("ext_int unmasked timer", 4'h0, ext_int);
        bus_write(EXTI_BASE, 16'h0002);
        check_irq("ext_int masked timer", 4'h2, ext_int);
        bus_write(EXTI_BASE, 16'h0000);
        check_irq("ext_int mask removed", 4'h0, ext_int);
        bus_write(TIMER_BASE, 16'h0000);
        bus_write(EXTI_BASE + 1, 16'h000F);
    endtask

    task automatic test_pwm();
        word_t q;
        int    p;
        int    d;
        int    high;
        int    exp;
        for (int t = 0; t < 3; t++)
        begin
            p = 2 + $unsigned($random(seed)) % 19;
            d = $unsigned($random(seed)) % (p + 4);
            bus_write(PWM_BASE, word_t'(p));
            bus_write(PWM_BASE + 1, word_t'(d));
            bus_write(EXTI_BASE + 1, 16'h0008);
            wait_cycles(p + 3);
            high = 0;
            repeat (p + 1)
            begin
                high += pwm;
                wait_cycles(1);
            end
            exp = (d < p + 1) ? d : p + 1;
            checks++;
            if (high != exp)
            begin
                errors++;
                $display("pwm was high for %0d cycles of %0d with duty %0d, expected %0d",
                         high, p + 1, d, exp);
            end
            bus_read(EXTI_BASE + 1, q);
            check_word("exti pending pwm bit", 16'h0008, q & 16'h0008);
        end
        bus_write(PWM_BASE + 1, 16'h0000);
        bus_write(PWM_BASE, 16'h0000);
        wait_cycles(2);
        bus_write(EXTI_BASE + 1, 16'h000F);
    endtask

    task automatic test_exti();
        word_t q;
        bus_write(EXTI_BASE + 2, 16'h0001);
        wait_cycles(1);
        bus_read(EXTI_BASE + 1, q);
        check_word("exti pending", 16'h0004, q);
        check_irq("ext_int before mask", 4'h0, ext_int);
        bus_write(EXTI_BASE, 16'h0004);
        check_irq("ext_int with mask", 4'h4, ext_int);
        bus_write(EXTI_BASE + 1, 16'h0004);
        check_irq("ext_int after clear", 4'h0, ext_int);
        bus_read(EXTI_BASE + 1, q);
        check_word("exti pending after clear", 16'h0000, q);
        bus_write(EXTI_BASE, 16'h0000);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        seed     = 32'h592b;
        errors   = 0;
        checks   = 0;
        clk      = 1'b0;
        arst_n   = 1'b0;
        enable   = 1'b0;
        addr     = '0;
        data_in  = '0;
        write_en = 1'b0;
        gpi      = '0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_reset();
        test_hwi();
        test_gpio();
        test_timer();
        test_pwm();
        test_exti();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
reflet_pkg.sv
reflet_hardware_info.sv
reflet_exti.sv
reflet_gpio.sv
reflet_timer.sv
reflet_pwm.sv
reflet_peripheral.sv
tb_reflet_peripheral.sv

// ==== Bender.yml ====
package:
  name: reflet_peripheral

export_include_dirs:
  - .

sources:
  - files:
      - reflet_pkg.sv
      - reflet_hardware_info.sv
      - reflet_exti.sv
      - reflet_gpio.sv
      - reflet_timer.sv
      - reflet_pwm.sv
      - reflet_peripheral.sv
  - target: test
    files:
      - tb_reflet_peripheral.sv
